//--- bench/StageID_tb.sv
`timescale 1ns/1ps

module StageID_tb
    import Types::*;
();

    localparam int cycleLimit = 400;  // About 200 cycles of tests, doubled

    // DUT ports, connected by name
    logic       i_clock;
    logic       i_rstN;
    Inst        i_inst;
    InstAddr    i_pc;
    RegAddr     i_EX_regWrAddr, i_MEM_regWrAddr, i_WB_regWrAddr;
    logic       i_EX_regWrEnable, i_EX_memRdEnable, i_MEM_regWrEnable;
    logic       i_MEM_memRdEnable, i_WB_regWrEnable;
    logic [1:0] i_EX_regWrDataSel;                         // 1 marks a load result
    Data        i_EX_regWrData, i_MEM_regWrData, i_WB_regWrData;
    Data        o_instIMM, o_dataA, o_dataB;
    logic       o_bubble;
    RegAddr     o_regWrAddr;
    logic       o_regWrEnable, o_memWrEnable, o_memRdEnable, o_memUnsigned;
    DataAccess  o_memAccess;
    logic [1:0] o_regWrDataSel, o_operandASel, o_operandBSel;
    AluOp       o_aluControl;
    InstAddr    o_pcNext;

    // --------------------
    // Scoreboard and expected values
    Data         model [32];          // Register file as written by WB
    Data         expImm, expDataA, expDataB;
    logic        expBubble;
    InstAddr     expPc;
    logic [11:0] expCtrl, ctrlMask, ctrlWord;
    RegAddr      expRd;
    AluOp        expAlu;
    logic        chkImm, chkPc;       // Per-cycle check enables
    logic        chkOp;               // rd and ALU operation
    int          errors, cycles;
    logic [31:0] r;
    InstAddr     pcVal;
    RegAddr      rs1, rs2;
    logic [2:0]  f3;
    logic [2:0]  branchF3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    logic [2:0]  loadF3 [5]   = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};

    StageID i_StageID (.*);

    assign ctrlWord = {o_regWrEnable, o_memWrEnable, o_memRdEnable, o_memUnsigned,
                       o_memAccess, o_regWrDataSel, o_operandASel, o_operandBSel};

    initial begin
        i_clock = 1'b0;
        forever #50 i_clock = ~i_clock;
    end

    always @(posedge i_clock) begin
        cycles <= cycles + 1;
        if (cycles == cycleLimit) begin
            $display("Timeout after %0d cycles, %0d errors so far", cycleLimit, errors);
            $display("Errors found");
            $finish;
        end
    end

    // --------------------
    // Instruction encoders per RV32I format
    function automatic Inst encI(input logic [11:0] imm, input RegAddr rs, input logic [2:0] fn,
                                 input RegAddr rd, input OpCode op);
        return {imm, rs, fn, rd, op};
    endfunction

    function automatic Inst encS(input logic [11:0] imm, input RegAddr rsB, input RegAddr rsA,
                                 input logic [2:0] fn);
        return {imm[11:5], rsB, rsA, fn, imm[4:0], opStore};
    endfunction

    function automatic Inst encB(input logic [12:0] imm, input RegAddr rsB, input RegAddr rsA,
                                 input logic [2:0] fn);
        return {imm[12], imm[10:5], rsB, rsA, fn, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic Inst encJ(input logic [20:0] imm, input RegAddr rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    function automatic Inst encR(input logic [6:0] fn7, input RegAddr rsB, input RegAddr rsA,
                                 input logic [2:0] fn, input RegAddr rd);
        return {fn7, rsB, rsA, fn, rd, opReg};
    endfunction

    // --------------------
    // Reference rules for operands, stall and branches
    function automatic Data expectOperand(input RegAddr rs);
        if (rs == '0)
            return '0;
        if (i_EX_regWrEnable && i_EX_regWrAddr == rs && i_EX_regWrDataSel != 2'd1)
            return i_EX_regWrData;
        if (i_MEM_regWrEnable && i_MEM_regWrAddr == rs)
            return i_MEM_regWrData;
        if (i_WB_regWrEnable && i_WB_regWrAddr == rs)
            return i_WB_regWrData;
        return model[rs];
    endfunction

    function automatic logic expectStall(input RegAddr rs);
        return rs != '0 && ((i_EX_memRdEnable && i_EX_regWrAddr == rs) ||
                            (i_MEM_memRdEnable && i_MEM_regWrAddr == rs));
    endfunction

    function automatic logic branchTaken(input logic [2:0] fn, input Data a, input Data b);
        case (fn)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;  // BGEU
        endcase
    endfunction

    task automatic predict();
        expDataA  = expectOperand(i_inst[19:15]);
        expDataB  = expectOperand(i_inst[24:20]);
        expBubble = expectStall(i_inst[19:15]) || expectStall(i_inst[24:20]);
    endtask

    task automatic quietStages();
        i_EX_regWrEnable  = 1'b0;
        i_EX_memRdEnable  = 1'b0;
        i_EX_regWrDataSel = 2'd0;
        i_MEM_regWrEnable = 1'b0;
        i_MEM_memRdEnable = 1'b0;
        i_WB_regWrEnable  = 1'b0;
        predict();
    endtask

    // Commit the WB write to the model, then drive 5 ns after the edge
    task automatic nextCycle();
        @(posedge i_clock);
        if (i_rstN && i_WB_regWrEnable && i_WB_regWrAddr != '0)
            model[i_WB_regWrAddr] = i_WB_regWrData;
        #5;
        i_WB_regWrEnable = 1'b0;
        chkImm   = 1'b0;
        chkPc    = 1'b0;
        chkOp    = 1'b0;
        ctrlMask = '0;
        predict();
    endtask

    task automatic issue(input Inst word, input InstAddr addr);
        i_inst = word;
        i_pc   = addr;
        predict();
    endtask

    task automatic checkCtrl(input Inst word, input logic [11:0] want, input logic [11:0] mask,
                             input logic opValid, input RegAddr rd, input AluOp alu);
        nextCycle();
        issue(word, 32'h0000_0100);
        expCtrl  = want;
        ctrlMask = mask;
        chkOp    = opValid;
        expRd    = rd;
        expAlu   = alu;
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] want,
                                  input logic [31:0] got);
        errors++;
        $display("[FAIL] %s expected %h actual %h", name, want, got);
    endtask

    // --------------------
    // Checks on the falling edge
    assert property (@(negedge i_clock) disable iff (!i_rstN) chkImm |-> o_instIMM == expImm)
        else reportMismatch("o_instIMM", expImm, o_instIMM);
    assert property (@(negedge i_clock) disable iff (!i_rstN) o_dataA == expDataA)
        else reportMismatch("o_dataA", expDataA, o_dataA);
    assert property (@(negedge i_clock) disable iff (!i_rstN) o_dataB == expDataB)
        else reportMismatch("o_dataB", expDataB, o_dataB);
    assert property (@(negedge i_clock) disable iff (!i_rstN) o_bubble == expBubble)
        else reportMismatch("o_bubble", 32'(expBubble), 32'(o_bubble));
    assert property (@(negedge i_clock) disable iff (!i_rstN) chkPc |-> o_pcNext == expPc)
        else reportMismatch("o_pcNext", expPc, o_pcNext);
    assert property (@(negedge i_clock) disable iff (!i_rstN)
                     (ctrlWord & ctrlMask) == (expCtrl & ctrlMask))
        else reportMismatch("control word", 32'(expCtrl & ctrlMask), 32'(ctrlWord & ctrlMask));
    assert property (@(negedge i_clock) disable iff (!i_rstN) chkOp |-> o_regWrAddr == expRd)
        else reportMismatch("o_regWrAddr", 32'(expRd), 32'(o_regWrAddr));
    assert property (@(negedge i_clock) disable iff (!i_rstN) chkOp |-> o_aluControl == expAlu)
        else reportMismatch("o_aluControl", 32'(expAlu), 32'(o_aluControl));

    initial begin
        r = $urandom(32'h49f5_a899);
        errors = 0;
        cycles = 0;
        chkImm = 1'b0;
        chkPc = 1'b0;
        chkOp = 1'b0;
        ctrlMask = '0;
        expCtrl = '0;
        expImm = '0;
        expPc = '0;
        expRd = '0;
        expAlu = ADD;
        for (int k = 0; k < 32; k++)
            model[k] = '0;
        i_inst = '0;                      // Fetch delivers zeros in reset
        i_pc = '0;
        i_EX_regWrAddr = '0;
        i_MEM_regWrAddr = '0;
        i_WB_regWrAddr = '0;
        i_EX_regWrData = '0;
        i_MEM_regWrData = '0;
        i_WB_regWrData = '0;
        quietStages();
        i_rstN = 1'b0;
        repeat (8) @(posedge i_clock);
        #5 i_rstN = 1'b1;

        // --------------------
        // Register file after reset, WB writes, read back
        for (int k = 0; k < 32; k += 2) begin
            nextCycle();
            issue(encR(7'h00, RegAddr'(k + 1), RegAddr'(k), 3'b000, 5'd0), '0);
        end
        for (int k = 0; k < 32; k++) begin
            nextCycle();
            i_WB_regWrEnable = 1'b1;      // Includes a write to x0
            i_WB_regWrAddr   = RegAddr'(k);
            i_WB_regWrData   = $urandom();
            predict();
        end
        for (int k = 0; k < 32; k += 2) begin
            nextCycle();
            issue(encR(7'h00, RegAddr'(k + 1), RegAddr'(k), 3'b000, 5'd0), '0);
        end

        // Immediates, rebuilt from the random fields
        for (int k = 0; k < 40; k++) begin
            nextCycle();
            r = $urandom();
            chkImm = 1'b1;
            case (k % 5)
                0: begin
                    issue(encI(r[11:0], 5'd1, 3'b000, 5'd3, opImm), '0);
                    expImm = {{20{r[11]}}, r[11:0]};
                end
                1: begin
                    issue(encS(r[11:0], 5'd2, 5'd1, 3'b010), '0);
                    expImm = {{20{r[11]}}, r[11:0]};
                end
                2: begin
                    issue(encB({r[31:20], 1'b0}, 5'd2, 5'd1, 3'b000), '0);
                    expImm = {{19{r[31]}}, r[31:20], 1'b0};
                end
                3: begin
                    issue({r[19:0], 5'd4, opLui}, '0);
                    expImm = {r[19:0], 12'b0};
                end
                default: begin
                    issue(encJ({r[20:1], 1'b0}, 5'd1), '0);
                    expImm = {{11{r[20]}}, r[20:1], 1'b0};
                end
            endcase
        end

        // Forwarding and bubble over x0 to x3 so that stages overlap
        for (int k = 0; k < 24; k++) begin
            nextCycle();
            r = $urandom();
            i_EX_regWrEnable  = r[0];
            i_EX_regWrAddr    = {3'b000, r[2:1]};
            i_EX_regWrDataSel = r[4:3];
            i_EX_memRdEnable  = r[5];
            i_EX_regWrData    = $urandom();
            i_MEM_regWrEnable = r[6];
            i_MEM_regWrAddr   = {3'b000, r[8:7]};
            i_MEM_memRdEnable = r[9];
            i_MEM_regWrData   = $urandom();
            i_WB_regWrEnable  = r[10];
            i_WB_regWrAddr    = {3'b000, r[12:11]};
            i_WB_regWrData    = $urandom();
            issue(encR(7'h00, {3'b000, r[14:13]}, {3'b000, r[16:15]}, 3'b000, 5'd0), '0);
        end
        quietStages();

        // --------------------
        // Branches, JAL, JALR
        for (int k = 0; k < 36; k++) begin
            nextCycle();
            r = $urandom();
            f3 = branchF3[k % 6];
            rs1 = 5'd1 + {1'b0, r[3:0]};
            rs2 = (r[5:4] == 2'b00) ? rs1 : 5'd1 + {1'b0, r[9:6]};  // Some equal pairs
            pcVal = $urandom() & 32'hffff_fffc;
            issue(encB({r[31:20], 1'b0}, rs2, rs1, f3), pcVal);
            expPc = branchTaken(f3, expDataA, expDataB) ?
                    pcVal + {{19{r[31]}}, r[31:20], 1'b0} : pcVal + 32'd4;
            chkPc = 1'b1;
        end
        for (int k = 0; k < 8; k++) begin
            nextCycle();
            r = $urandom();
            pcVal = $urandom() & 32'hffff_fffc;
            if (k < 4) begin
                issue(encJ({r[20:1], 1'b0}, 5'd1), pcVal);
                expPc = pcVal + {{11{r[20]}}, r[20:1], 1'b0};
            end else begin
                i_EX_regWrEnable  = r[0];  // Base from EX on some cases
                i_EX_regWrAddr    = 5'd5;
                i_EX_regWrDataSel = 2'd0;
                i_EX_regWrData    = $urandom();
                issue(encI(r[31:20], 5'd5, 3'b000, 5'd1, opJalr), pcVal);
                expPc = (expDataA + {{20{r[31]}}, r[31:20]}) & ~32'd1;
            end
            chkPc = 1'b1;
        end
        quietStages();

        // Control word, bits {wr, st, ld, uns, size, wrSel, aSel, bSel}
        foreach (loadF3[k])
            checkCtrl(encI(12'h010, 5'd2, loadF3[k], 5'd6, opLoad),
                      {3'b101, loadF3[k][2], loadF3[k][1:0], 2'd1, 2'd0, 2'd1}, 12'hfff,
                      1'b1, 5'd6, ADD);
        for (int k = 0; k < 3; k++)
            checkCtrl(encS(12'h024, 5'd3, 5'd2, 3'(k)),
                      {3'b010, 1'b0, 2'(k), 2'd0, 2'd0, 2'd1}, 12'hfff,
                      1'b1, 5'd4, ADD);                     // rd field holds imm[4:0]
        checkCtrl(encR(7'h00, 5'd3, 5'd2, 3'b000, 5'd7), 12'h800, 12'he3f,
                  1'b1, 5'd7, ADD);                         // ADD
        checkCtrl(encR(7'h20, 5'd3, 5'd2, 3'b000, 5'd7), 12'h800, 12'he3f,
                  1'b1, 5'd7, SUB);                         // SUB
        checkCtrl(32'h0000_0000, 12'h000, 12'he00, 1'b0, 5'd0, ADD);  // All zero
        checkCtrl(32'h0000_0073, 12'h000, 12'he00, 1'b0, 5'd0, ADD);  // ECALL
        checkCtrl(encR(7'h01, 5'd3, 5'd2, 3'b000, 5'd7), 12'h000, 12'he00,
                  1'b0, 5'd0, ADD);                         // MUL
        nextCycle();

        $display("Run ended after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- project.f
+incdir+verilog
verilog/Types.sv
verilog/InstDecoder.sv
verilog/DatapathController.sv
verilog/HazardUnit.sv
verilog/RegisterFile.sv
verilog/BranchUnit.sv
verilog/StageID.sv
bench/StageID_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the StageID testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=StageID_sim

if ! verilator --binary --timing --assert --top-module StageID_tb \
        -f project.f --Mdir "$OBJ" -o "$BIN"; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$OBJ/$BIN" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"
if grep -qx "No errors" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

//--- verilog/BranchUnit.sv
`timescale 1ns/1ps
`include "RV_defs.svh"

module BranchUnit
    import Types::*;
(
    input  Data     i_dataA,      // Forwarded rs1
    input  Data     i_dataB,      // Forwarded rs2
    input  Data     i_instIMM,    // Branch or jump offset
    input  InstAddr i_pc,         // Current PC
    input  PcSel    i_pcNextSel,  // From controller
    output logic    o_isEqual,
    output logic    o_isLess,     // Signed
    output logic    o_isLessU,    // Unsigned
    output InstAddr o_pcNext
);

    InstAddr jumpTarget;  // rs1 + imm before bit 0 clear

    assign o_isEqual  = i_dataA == i_dataB;
    assign o_isLess   = $signed(i_dataA) < $signed(i_dataB);
    assign o_isLessU  = i_dataA < i_dataB;
    assign jumpTarget = i_dataA + i_instIMM;

    always_comb begin
        case (i_pcNextSel)
            BRANCH:  o_pcNext = i_pc + i_instIMM;                         // Taken branch, JAL
            JALR:    o_pcNext = {jumpTarget[`RV_DATA_W-1:1], 1'b0};
            default: o_pcNext = i_pc + InstAddr'(`RV_PC_INC);             // Fall through
        endcase
    end

endmodule

//--- verilog/DatapathController.sv
`timescale 1ns/1ps

module DatapathController
    import Types::*;
(
    input  Inst        i_inst,          // Current instruction
    input  logic       i_isEqual,       // rs1 == rs2
    input  logic       i_isLess,        // rs1 < rs2 signed
    input  logic       i_isLessU,       // rs1 < rs2 unsigned
    input  logic       i_isIllegal,     // From decoder
    output logic       o_regWrEnable,   // Write rd
    output logic       o_memWrEnable,   // Store
    output logic       o_memRdEnable,   // Load
    output logic       o_memUnsigned,   // Zero-extend load
    output DataAccess  o_memAccess,     // Access size
    output logic [1:0] o_regWrDataSel,  // 0 ALU, 1 memory, 2 pc+4
    output logic [1:0] o_operandASel,   // 0 rs1, 1 pc, 2 zero
    output logic [1:0] o_operandBSel,   // 0 rs2, 1 immediate
    output AluOp       o_aluControl,    // ALU operation
    output PcSel       o_pcNextSel      // Next PC source
);

    OpCode      opCode;
    logic [2:0] funct3;
    logic       altFn;    // funct7 bit 5
    logic       brTaken;  // Branch condition holds
    AluOp       aluFn;    // Operation from funct3

    assign opCode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign altFn  = i_inst[30];

    always_comb begin
        case (funct3)
            3'b000:  brTaken = i_isEqual;    // BEQ
            3'b001:  brTaken = !i_isEqual;   // BNE
            3'b100:  brTaken = i_isLess;     // BLT
            3'b101:  brTaken = !i_isLess;    // BGE
            3'b110:  brTaken = i_isLessU;    // BLTU
            3'b111:  brTaken = !i_isLessU;   // BGEU
            default: brTaken = 1'b0;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  aluFn = (opCode == opReg && altFn) ? SUB : ADD;  // No SUBI
            3'b001:  aluFn = SLL;
            3'b010:  aluFn = SLT;
            3'b011:  aluFn = SLTU;
            3'b100:  aluFn = XOR;
            3'b101:  aluFn = altFn ? SRA : SRL;
            3'b110:  aluFn = OR;
            default: aluFn = AND;
        endcase
    end

    always_comb begin
        o_regWrEnable  = 1'b0;
        o_memWrEnable  = 1'b0;
        o_memRdEnable  = 1'b0;
        o_memUnsigned  = funct3[2];               // LBU, LHU
        o_memAccess    = funct3[1:0] == 2'b00 ? BYTE :
                         funct3[1:0] == 2'b01 ? HALF : WORD;
        o_regWrDataSel = 2'd0;
        o_operandASel  = 2'd0;
        o_operandBSel  = 2'd0;
        o_aluControl   = ADD;
        o_pcNextSel    = PLUS4;

        case (opCode)
            opLui: begin
                o_regWrEnable = 1'b1;
                o_operandBSel = 2'd1;
                o_aluControl  = PASSB;            // rd = imm
            end
            opAuipc: begin
                o_regWrEnable = 1'b1;
                o_operandASel = 2'd1;             // pc + imm
                o_operandBSel = 2'd1;
            end
            opJal, opJalr: begin
                o_regWrEnable  = 1'b1;
                o_regWrDataSel = 2'd2;            // Link address
                o_pcNextSel    = opCode == opJal ? BRANCH : JALR;
            end
            opBranch: o_pcNextSel = brTaken ? BRANCH : PLUS4;
            opLoad: begin
                o_regWrEnable  = 1'b1;
                o_memRdEnable  = 1'b1;
                o_regWrDataSel = 2'd1;
                o_operandBSel  = 2'd1;            // Address rs1 + imm
            end
            opStore: begin
                o_memWrEnable = 1'b1;
                o_operandBSel = 2'd1;
            end
            opImm: begin
                o_regWrEnable = 1'b1;
                o_operandBSel = 2'd1;
                o_aluControl  = aluFn;
            end
            opReg: begin
                o_regWrEnable = 1'b1;
                o_aluControl  = aluFn;
            end
            default: ;
        endcase

        // Illegal words never write or touch memory
        if (i_isIllegal) begin
            o_regWrEnable = 1'b0;
            o_memWrEnable = 1'b0;
            o_memRdEnable = 1'b0;
            o_pcNextSel   = PLUS4;
        end
    end

endmodule

//--- verilog/HazardUnit.sv
`timescale 1ns/1ps

module HazardUnit
    import Types::*;
(
    input  RegAddr     i_instRS1,
    input  RegAddr     i_instRS2,
    input  RegAddr     i_EX_regWrAddr,
    input  RegAddr     i_MEM_regWrAddr,
    input  RegAddr     i_WB_regWrAddr,
    input  logic       i_EX_regWrEnable,
    input  logic       i_EX_memRdEnable,   // Load in EX
    input  logic       i_MEM_regWrEnable,
    input  logic       i_MEM_memRdEnable,  // Load in MEM
    input  logic       i_WB_regWrEnable,
    input  logic [1:0] i_EX_regWrDataSel,  // 1 means memory data
    output FwdSel      o_dataASel,         // rs1 source
    output FwdSel      o_dataBSel,         // rs2 source
    output logic       o_bubble            // Load-use stall
);

    // Newest writer wins, x0 is never forwarded
    function automatic FwdSel pickSource(input RegAddr rs);
        FwdSel sel;
        sel = REG;
        if (rs != '0) begin
            if (i_EX_regWrEnable && i_EX_regWrAddr == rs && i_EX_regWrDataSel != 2'd1)
                sel = EX;                  // Load result not ready
            else if (i_MEM_regWrEnable && i_MEM_regWrAddr == rs)
                sel = MEM;
            else if (i_WB_regWrEnable && i_WB_regWrAddr == rs)
                sel = WB;
        end
        return sel;
    endfunction

    function automatic logic loadPending(input RegAddr rs);
        return rs != '0 && ((i_EX_memRdEnable && i_EX_regWrAddr == rs) ||
                            (i_MEM_memRdEnable && i_MEM_regWrAddr == rs)); // For branches
    endfunction

    always_comb begin
        o_dataASel = pickSource(i_instRS1);
        o_dataBSel = pickSource(i_instRS2);
        o_bubble   = loadPending(i_instRS1) || loadPending(i_instRS2);
    end

endmodule

//--- verilog/InstDecoder.sv
`timescale 1ns/1ps

module InstDecoder
    import Types::*;
(
    input  Inst    i_inst,      // Fetched word
    output OpCode  o_instOP,    // Major opcode
    output RegAddr o_instRS1,   // Source register 1
    output RegAddr o_instRS2,   // Source register 2
    output RegAddr o_instRD,    // Destination register
    output Data    o_instIMM,   // Sign-extended immediate
    output logic   o_isIllegal  // Unsupported encoding
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign o_instOP  = i_inst[6:0];
    assign o_instRD  = i_inst[11:7];
    assign funct3    = i_inst[14:12];
    assign o_instRS1 = i_inst[19:15];
    assign o_instRS2 = i_inst[24:20];
    assign funct7    = i_inst[31:25];

    always_comb begin
        // --------------------
        // Immediate by format
        case (o_instOP)
            opLui, opAuipc: o_instIMM = {i_inst[31:12], 12'b0};                     // U
            opJal:          o_instIMM = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                                         i_inst[20], i_inst[30:21], 1'b0};          // J
            opBranch:       o_instIMM = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                                         i_inst[30:25], i_inst[11:8], 1'b0};        // B
            opStore:        o_instIMM = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]}; // S
            opJalr, opLoad, opImm:
                            o_instIMM = {{20{i_inst[31]}}, i_inst[31:20]};          // I
            default:        o_instIMM = '0;                                         // R or none
        endcase

        // --------------------
        // Legality per opcode
        case (o_instOP)
            opLui, opAuipc, opJal: o_isIllegal = 1'b0;
            opJalr:   o_isIllegal = funct3 != 3'b000;
            opBranch: o_isIllegal = funct3[2:1] == 2'b01;                    // 010, 011 unused
            opLoad:   o_isIllegal = funct3 == 3'b011 || funct3[2:1] == 2'b11; // No LWU, LD
            opStore:  o_isIllegal = funct3[2] || funct3[1:0] == 2'b11;       // SB, SH, SW only
            opImm: begin
                case (funct3)
                    3'b001:  o_isIllegal = funct7 != 7'b0000000;             // SLLI
                    3'b101:  o_isIllegal = funct7 != 7'b0000000 && funct7 != 7'b0100000;
                    default: o_isIllegal = 1'b0;
                endcase
            end
            opReg:    o_isIllegal = !(funct7 == 7'b0000000 ||
                                      (funct7 == 7'b0100000 &&
                                       (funct3 == 3'b000 || funct3 == 3'b101))); // SUB, SRA
            default:  o_isIllegal = 1'b1;                                    // Includes all-zero
        endcase
    end

endmodule

//--- verilog/RV_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// --------------------
// RV32I widths

// Data and address width
`define RV_DATA_W 32
// Register count
`define RV_REG_N  32
// Register index width
`define RV_REG_AW 5
// Sequential PC step
`define RV_PC_INC 4

`endif

//--- verilog/RegisterFile.sv
`timescale 1ns/1ps
`include "RV_defs.svh"

module RegisterFile
    import Types::*;
(
    input  logic   i_clock,
    input  logic   i_rstN,      // Clears all registers
    input  logic   i_wrEnable,  // Write from WB
    input  RegAddr i_wrAddr,
    input  RegAddr i_rdAddrA,
    input  RegAddr i_rdAddrB,
    input  Data    i_wrData,
    output Data    o_rdDataA,   // Async read A
    output Data    o_rdDataB    // Async read B
);

    Data regs [`RV_REG_N];

    always_ff @(posedge i_clock) begin
        if (!i_rstN) begin
            for (int i = 0; i < `RV_REG_N; i++)
                regs[i] <= '0;
        end else if (i_wrEnable && i_wrAddr != '0) begin  // x0 is hardwired
            regs[i_wrAddr] <= i_wrData;
        end
    end

    assign o_rdDataA = (i_rdAddrA == '0) ? '0 : regs[i_rdAddrA];
    assign o_rdDataB = (i_rdAddrB == '0) ? '0 : regs[i_rdAddrB];

endmodule

//--- verilog/StageID.sv
`timescale 1ns/1ps

module StageID
    import Types::*;
(
    input  logic       i_clock,
    input  logic       i_rstN,
    input  Inst        i_inst,             // Fetched instruction
    input  InstAddr    i_pc,               // Its address
    input  RegAddr     i_EX_regWrAddr,
    input  logic       i_EX_regWrEnable,
    input  logic [1:0] i_EX_regWrDataSel,
    input  Data        i_EX_regWrData,
    input  logic       i_EX_memRdEnable,
    input  RegAddr     i_MEM_regWrAddr,
    input  logic       i_MEM_regWrEnable,
    input  Data        i_MEM_regWrData,
    input  logic       i_MEM_memRdEnable,
    input  RegAddr     i_WB_regWrAddr,
    input  logic       i_WB_regWrEnable,   // Also the register file write
    input  Data        i_WB_regWrData,
    output Data        o_instIMM,
    output Data        o_dataA,            // Forwarded rs1
    output Data        o_dataB,            // Forwarded rs2
    output logic       o_bubble,
    output RegAddr     o_regWrAddr,
    output logic       o_regWrEnable,
    output logic       o_memWrEnable,
    output logic       o_memRdEnable,
    output logic       o_memUnsigned,
    output DataAccess  o_memAccess,
    output logic [1:0] o_regWrDataSel,
    output logic [1:0] o_operandASel,
    output logic [1:0] o_operandBSel,
    output AluOp       o_aluControl,
    output InstAddr    o_pcNext
);

    OpCode  decInstOP;
    RegAddr decInstRS1;
    RegAddr decInstRS2;
    logic   decIsIllegal;
    PcSel   ctrlPcNextSel;
    FwdSel  hazDataASel;
    FwdSel  hazDataBSel;
    Data    regsDataA;
    Data    regsDataB;
    logic   brIsEqual;
    logic   brIsLess;
    logic   brIsLessU;

    // --------------------
    // Decode and control
    InstDecoder dec (
        .i_inst      (i_inst),
        .o_instOP    (decInstOP),
        .o_instRS1   (decInstRS1),
        .o_instRS2   (decInstRS2),
        .o_instRD    (o_regWrAddr),
        .o_instIMM   (o_instIMM),
        .o_isIllegal (decIsIllegal));

    DatapathController dpCtrl (
        .i_inst         (i_inst),
        .i_isEqual      (brIsEqual),
        .i_isLess       (brIsLess),
        .i_isLessU      (brIsLessU),
        .i_isIllegal    (decIsIllegal),
        .o_regWrEnable  (o_regWrEnable),
        .o_memWrEnable  (o_memWrEnable),
        .o_memRdEnable  (o_memRdEnable),
        .o_memUnsigned  (o_memUnsigned),
        .o_memAccess    (o_memAccess),
        .o_regWrDataSel (o_regWrDataSel),
        .o_operandASel  (o_operandASel),
        .o_operandBSel  (o_operandBSel),
        .o_aluControl   (o_aluControl),
        .o_pcNextSel    (ctrlPcNextSel));

    // --------------------
    // Hazards and operands
    HazardUnit hazard (
        .i_instRS1         (decInstRS1),
        .i_instRS2         (decInstRS2),
        .i_EX_regWrAddr    (i_EX_regWrAddr),
        .i_MEM_regWrAddr   (i_MEM_regWrAddr),
        .i_WB_regWrAddr    (i_WB_regWrAddr),
        .i_EX_regWrEnable  (i_EX_regWrEnable),
        .i_EX_memRdEnable  (i_EX_memRdEnable),
        .i_MEM_regWrEnable (i_MEM_regWrEnable),
        .i_MEM_memRdEnable (i_MEM_memRdEnable),
        .i_WB_regWrEnable  (i_WB_regWrEnable),
        .i_EX_regWrDataSel (i_EX_regWrDataSel),
        .o_dataASel        (hazDataASel),
        .o_dataBSel        (hazDataBSel),
        .o_bubble          (o_bubble));

    RegisterFile regs (
        .i_clock    (i_clock),
        .i_rstN     (i_rstN),
        .i_wrEnable (i_WB_regWrEnable),
        .i_wrAddr   (i_WB_regWrAddr),
        .i_rdAddrA  (decInstRS1),
        .i_rdAddrB  (decInstRS2),
        .i_wrData   (i_WB_regWrData),
        .o_rdDataA  (regsDataA),
        .o_rdDataB  (regsDataB));

    // Four-way operand select
    function automatic Data fwdMux(input FwdSel sel, input Data regData);
        case (sel)
            EX:      return i_EX_regWrData;
            MEM:     return i_MEM_regWrData;
            WB:      return i_WB_regWrData;   // Covers same-cycle write
            default: return regData;
        endcase
    endfunction

    always_comb begin
        o_dataA = fwdMux(hazDataASel, regsDataA);
        o_dataB = fwdMux(hazDataBSel, regsDataB);
    end

    // --------------------
    // Branch resolution
    BranchUnit branch (
        .i_dataA     (o_dataA),
        .i_dataB     (o_dataB),
        .i_instIMM   (o_instIMM),
        .i_pc        (i_pc),
        .i_pcNextSel (ctrlPcNextSel),
        .o_isEqual   (brIsEqual),
        .o_isLess    (brIsLess),
        .o_isLessU   (brIsLessU),
        .o_pcNext    (o_pcNext));

    // Memory enables only for load and store opcodes
    assert property (@(posedge i_clock) disable iff (!i_rstN)
        (o_memRdEnable |-> decInstOP == opLoad) and (o_memWrEnable |-> decInstOP == opStore));

endmodule

//--- verilog/Types.sv
`include "RV_defs.svh"

package Types;

    typedef logic [`RV_DATA_W-1:0] Data;      // Register value, operand, immediate
    typedef logic [`RV_DATA_W-1:0] InstAddr;  // Instruction address
    typedef logic [31:0]           Inst;      // Instruction word
    typedef logic [`RV_REG_AW-1:0] RegAddr;   // Register index
    typedef logic [6:0]            OpCode;    // Major opcode

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASSB
    } AluOp;

    typedef enum logic [1:0] {BYTE, HALF, WORD} DataAccess;  // Memory access size
    typedef enum logic [1:0] {REG, EX, MEM, WB} FwdSel;      // Operand source
    typedef enum logic [1:0] {PLUS4, BRANCH, JALR} PcSel;    // Next PC source

    // --------------------
    // Supported major opcodes
    localparam OpCode opLui    = 7'b0110111;
    localparam OpCode opAuipc  = 7'b0010111;
    localparam OpCode opJal    = 7'b1101111;
    localparam OpCode opJalr   = 7'b1100111;
    localparam OpCode opBranch = 7'b1100011;
    localparam OpCode opLoad   = 7'b0000011;
    localparam OpCode opStore  = 7'b0100011;
    localparam OpCode opImm    = 7'b0010011;
    localparam OpCode opReg    = 7'b0110011;

endpackage
